// ==== id_stage.f ====
rtl/rv_isa_pkg.sv
rtl/id_pipe_pkg.sv
rtl/id_decoder.sv
rtl/id_regfile.sv
rtl/id_operand_sel.sv
rtl/id_hazard_unit.sv
rtl/id_stage.sv
tb/id_stage_sva.sv
tb/id_stage_checker.sv
tb/id_stage_tb.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - rtl/rv_isa_pkg.sv
  - rtl/id_pipe_pkg.sv
  - rtl/id_decoder.sv
  - rtl/id_regfile.sv
  - rtl/id_operand_sel.sv
  - rtl/id_hazard_unit.sv
  - rtl/id_stage.sv
  - target: test
    files:
      - tb/id_stage_sva.sv
      - tb/id_stage_checker.sv
      - tb/id_stage_tb.sv

// ==== tb/id_stage_tb.sv ====
// Decode stage testbench
`timescale 1ns/1ps

module id_stage_tb;

  localparam int N_ENTRIES = 24;
  localparam int CYCLE_LIMIT = 4 * N_ENTRIES + 50;

  // One table row, one clock of stimulus and its expectations
  typedef struct packed {
    logic                valid;
    logic [31:0]         pc;
    logic [31:0]         instr;
    id_pipe_pkg::rf_wr_t ex;
    id_pipe_pkg::rf_wr_t wb;
    logic                ex_ready;
    logic                e_ready;
    logic                e_valid;
    logic [3:0]          chk;    // ab, rd, bt, sd
    logic [31:0]         e_a;
    logic [31:0]         e_b;
    logic [31:0]         e_sd;
    logic [31:0]         e_bt;
    logic [4:0]          e_rd;
    logic [4:0]          e_evt;  // instret, load, store, jump, branch
  } entry_t;

  logic                clk;
  logic                rst_n;
  id_pipe_pkg::if_id_t if_id;
  logic                id_ready;
  logic                ex_ready;
  id_pipe_pkg::rf_wr_t ex_fwd;
  id_pipe_pkg::rf_wr_t wb_wr;
  id_pipe_pkg::id_ex_t id_ex;
  logic [4:0]          evt;
  entry_t              tbl[$];
  entry_t              cur;
  logic                active;
  logic [31:0]         lfsr;
  logic [31:0]         r [0:5];
  int                  cycles;
  int                  errors;
  int                  tests;

  id_stage u_dut (
    .clk           ( clk      ),
    .rst_n         ( rst_n    ),
    .if_id_i       ( if_id    ),
    .id_ready_o    ( id_ready ),
    .ex_ready_i    ( ex_ready ),
    .ex_fwd_i      ( ex_fwd   ),
    .wb_wr_i       ( wb_wr    ),
    .id_ex_o       ( id_ex    ),
    .evt_instret_o ( evt[4]   ),
    .evt_load_o    ( evt[3]   ),
    .evt_store_o   ( evt[2]   ),
    .evt_jump_o    ( evt[1]   ),
    .evt_branch_o  ( evt[0]   )
  );

  id_stage_checker u_checker (
    .clk        ( clk      ),
    .active_i   ( active   ),
    .row_i      ( cur      ),
    .id_ready_i ( id_ready ),
    .id_ex_i    ( id_ex    ),
    .evt_i      ( evt      ),
    .errors_o   ( errors   ),
    .tests_o    ( tests    )
  );

  bind id_stage id_stage_sva u_sva (.*);

  always #2 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // One new bit per step
  task automatic rand_word(output logic [31:0] w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[30:0], lfsr[0]};
    end
  endtask

  ////////////////////
  // Instruction encoders
  function automatic logic [31:0] enc_r(input logic [4:0] rs2, rs1, rd);
    return {7'h00, rs2, rs1, 3'b000, rd, rv_isa_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2, rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_isa_pkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2, rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], rv_isa_pkg::OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_isa_pkg::OPC_JAL};
  endfunction

  // Append one row
  task automatic push(input logic v, input logic [31:0] pc, instr,
                      input id_pipe_pkg::rf_wr_t ex, wb, input logic exr, e_rdy, e_v,
                      input logic [3:0] chk, input logic [31:0] a, b, sd, bt,
                      input logic [4:0] rd, evt_exp);
    tbl.push_back('{v, pc, instr, ex, wb, exr, e_rdy, e_v, chk, a, b, sd, bt, rd, evt_exp});
  endtask

  task automatic build_table();
    id_pipe_pkg::rf_wr_t n;
    n = '0;
    // Register setup through WB, x0 write dropped
    push(0, 0, 0, n, '{1'b1, 5'd1, r[0]}, 1, 1, 0, 4'b0000, 0, 0, 0, 0, 0, 5'b00000);
    push(0, 0, 0, n, '{1'b1, 5'd2, r[1]}, 1, 1, 0, 4'b0000, 0, 0, 0, 0, 0, 5'b00000);
    push(0, 0, 0, n, '{1'b1, 5'd0, r[2]}, 1, 1, 0, 4'b0000, 0, 0, 0, 0, 0, 5'b00000);
    // Formats and immediates
    push(1, 32'h100, enc_i(12'hFFD, 1, 3'b000, 5, rv_isa_pkg::OPC_OP_IMM), n, n, 1, 1, 1,
         4'b1100, r[0], 32'hFFFF_FFFD, 0, 0, 5, 5'b10000);
    push(1, 32'h104, enc_s(12'd20, 2, 1), n, n, 1, 1, 1,
         4'b1001, r[0], 32'd20, r[1], 0, 0, 5'b10100);
    push(1, 32'h108, enc_u(20'h12345, 6, rv_isa_pkg::OPC_LUI), n, n, 1, 1, 1,
         4'b1100, 0, 32'h1234_5000, 0, 0, 6, 5'b10000);
    push(1, 32'h10C, enc_u(20'h00001, 7, rv_isa_pkg::OPC_AUIPC), n, n, 1, 1, 1,
         4'b1100, 32'h10C, 32'h1000, 0, 0, 7, 5'b10000);
    push(1, 32'h110, enc_b(13'h1FF8, 2, 1), n, n, 1, 1, 1,
         4'b1010, r[0], r[1], 0, 32'h108, 0, 5'b10001);
    push(1, 32'h114, enc_r(2, 0, 8), n, n, 1, 1, 1, 4'b1100, 0, r[1], 0, 0, 8, 5'b10000);
    // Forwarding priority EX, WB, register file
    push(1, 32'h118, enc_r(3, 3, 9), '{1'b1, 5'd3, r[3]}, '{1'b1, 5'd3, r[4]}, 1, 1, 1,
         4'b1100, r[3], r[3], 0, 0, 9, 5'b10000);
    push(1, 32'h11C, enc_r(3, 3, 9), n, '{1'b1, 5'd3, r[4]}, 1, 1, 1,
         4'b1100, r[4], r[4], 0, 0, 9, 5'b10000);
    push(1, 32'h120, enc_r(0, 3, 10), n, n, 1, 1, 1, 4'b1100, r[4], 0, 0, 0, 10, 5'b10000);
    // Jumps and an illegal word
    push(1, 32'h200, enc_j(21'd16, 1), n, n, 1, 1, 1,
         4'b1110, 32'h200, 32'd4, 0, 32'h210, 1, 5'b10010);
    push(1, 32'h204, enc_i(12'd6, 2, 3'b000, 11, rv_isa_pkg::OPC_JALR), n, n, 1, 1, 1,
         4'b1110, 32'h204, 32'd4, 0, (r[1] + 32'd6) & ~32'd1, 11, 5'b10010);
    push(1, 32'h208, 32'h0000_007F, n, n, 1, 1, 1, 4'b0000, 0, 0, 0, 0, 0, 5'b00000);
    // Load-use stall, then an independent follower
    push(1, 32'h300, enc_i(12'd0, 1, 3'b010, 12, rv_isa_pkg::OPC_LOAD), n, n, 1, 1, 1,
         4'b1100, r[0], 0, 0, 0, 12, 5'b11000);
    push(1, 32'h304, enc_r(2, 12, 13), n, n, 1, 0, 0, 4'b0000, 0, 0, 0, 0, 0, 5'b00000);
    push(1, 32'h304, enc_r(2, 12, 13), '{1'b1, 5'd12, r[5]}, n, 1, 1, 1,
         4'b1100, r[5], r[1], 0, 0, 13, 5'b10000);
    push(1, 32'h308, enc_i(12'd4, 1, 3'b010, 14, rv_isa_pkg::OPC_LOAD), n, n, 1, 1, 1,
         4'b1100, r[0], 32'd4, 0, 0, 14, 5'b11000);
    push(1, 32'h30C, enc_r(2, 1, 15), n, n, 1, 1, 1, 4'b1100, r[0], r[1], 0, 0, 15, 5'b10000);
    // Back-pressure holds the previous item
    push(1, 32'h310, enc_i(12'd1, 2, 3'b000, 16, rv_isa_pkg::OPC_OP_IMM), n, n, 0, 0, 1,
         4'b1100, r[0], r[1], 0, 0, 15, 5'b00000);
    push(1, 32'h310, enc_i(12'd1, 2, 3'b000, 16, rv_isa_pkg::OPC_OP_IMM), n, n, 0, 0, 1,
         4'b1100, r[0], r[1], 0, 0, 15, 5'b00000);
    push(1, 32'h310, enc_i(12'd1, 2, 3'b000, 16, rv_isa_pkg::OPC_OP_IMM), n, n, 1, 1, 1,
         4'b1100, r[1], 32'd1, 0, 0, 16, 5'b10000);
    push(0, 0, 0, n, n, 1, 1, 0, 4'b0000, 0, 0, 0, 0, 0, 5'b00000);
  endtask

  task automatic apply(input entry_t e);
    if_id.valid = e.valid;
    if_id.pc    = e.pc;
    if_id.instr = rv_isa_pkg::instr_fmt_u'(e.instr);
    ex_fwd      = e.ex;
    wb_wr       = e.wb;
    ex_ready    = e.ex_ready;
  endtask

  // Run limit
  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    clk = 0;
    rst_n = 0;
    if_id = '0;
    ex_fwd = '0;
    wb_wr = '0;
    ex_ready = 0;
    cur = '0;
    active = 1'b0;
    cycles = 0;
    lfsr = 32'h3255_ce4b;
    for (int i = 0; i < 6; i++) begin
      rand_word(r[i]);
    end
    build_table();
    repeat (5) @(posedge clk);
    #1 rst_n = 1;
    foreach (tbl[i]) begin
      @(posedge clk);
      #1;
      apply(tbl[i]);
      cur = tbl[i];
      active = 1'b1;
    end
    @(posedge clk);
    #1;
    apply('0);
    active = 1'b0;
    @(negedge clk);
    #1;
    $display("Tests finished: %0d of %0d, errors: %0d", tests, tbl.size(), errors);
    if (errors == 0 && tests == tbl.size()) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// ==== tb/id_stage_checker.sv ====
// Decode stage output checker
`timescale 1ns/1ps

module id_stage_checker (
  input  logic                clk,
  input  logic                active_i,
  input  logic [285:0]        row_i,
  input  logic                id_ready_i,
  input  id_pipe_pkg::id_ex_t id_ex_i,
  input  logic [4:0]          evt_i,
  output int                  errors_o,
  output int                  tests_o
);

  // Field slices of one table row, top down
  logic [285:0] prev;
  logic [31:0]  exp_pc;
  logic         prev_act;
  logic         prev_bad;
  logic         bad;
  int           idx;

  task automatic cmp(input string name, input logic [31:0] exp, got);
    if (exp !== got) begin
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
      errors_o++;
      bad = 1'b1;
    end
  endtask

  initial begin
    errors_o = 0;
    tests_o  = 0;
    exp_pc   = '0;
    prev_act = 1'b0;
    prev_bad = 1'b0;
    idx      = 0;
  end

  // Ready belongs to this cycle, id_ex_o and events to the last one
  always @(negedge clk) begin
    if (prev_act) begin
      bad = prev_bad;
      cmp("id_ex_o.valid", prev[142], id_ex_i.valid);
      if (prev[142]) begin
        cmp("id_ex_o.pc", exp_pc, id_ex_i.pc);
        if (prev[141]) cmp("id_ex_o.operand_a", prev[137:106], id_ex_i.operand_a);
        if (prev[141]) cmp("id_ex_o.operand_b", prev[105:74], id_ex_i.operand_b);
        if (prev[140]) cmp("id_ex_o.rd", prev[9:5], id_ex_i.rd);
        if (prev[139]) cmp("id_ex_o.branch_target", prev[41:10], id_ex_i.branch_target);
        if (prev[138]) cmp("id_ex_o.store_data", prev[73:42], id_ex_i.store_data);
      end
      cmp("evt", prev[4:0], evt_i);
      $display("Test %0d %s", idx, bad ? "failed" : "passed");
      tests_o++;
      idx++;
    end
    bad = 1'b0;
    if (active_i) begin
      cmp("id_ready_o", row_i[143], id_ready_i);
      // Accepted rows set the pc seen on id_ex_o, held rows keep it
      if (row_i[285] && row_i[143]) begin
        exp_pc = row_i[284:253];
      end
    end
    prev_bad = bad;
    prev_act = active_i;
    prev     = row_i;
  end

endmodule

// ==== tb/id_stage_sva.sv ====
// Decode stage flow control assertions
`timescale 1ns/1ps

module id_stage_sva (
  input logic                clk,
  input logic                rst_n,
  input logic                ex_ready_i,
  input logic                load_stall,
  input logic                evt_instret_o,
  input id_pipe_pkg::id_ex_t id_ex_o
);

  // Held item must not move under back-pressure
  a_hold: assert property (@(posedge clk) disable iff (!rst_n)
    id_ex_o.valid && !ex_ready_i |=> $stable(id_ex_o))
    else $error("id_ex_o changed while EX was not ready");

  a_reset: assert property (@(posedge clk)
    !rst_n |-> !id_ex_o.valid && !id_ex_o.rf_we && !id_ex_o.data_req && !evt_instret_o)
    else $error("outputs active during reset");

  // Load-use stall drains into one bubble
  a_stall: assert property (@(posedge clk) disable iff (!rst_n)
    load_stall && ex_ready_i |=> !id_ex_o.valid)
    else $error("load-use stall did not insert a bubble");

endmodule

// ==== rtl/id_stage.sv ====
// Instruction decode stage
`timescale 1ns/1ps

module id_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  id_pipe_pkg::if_id_t if_id_i,
  output logic                id_ready_o,
  input  logic                ex_ready_i,
  input  id_pipe_pkg::rf_wr_t ex_fwd_i,
  input  id_pipe_pkg::rf_wr_t wb_wr_i,
  output id_pipe_pkg::id_ex_t id_ex_o,
  output logic                evt_instret_o,
  output logic                evt_load_o,
  output logic                evt_store_o,
  output logic                evt_jump_o,
  output logic                evt_branch_o
);

  id_pipe_pkg::dec_ctrl_t      ctrl;
  id_pipe_pkg::fw_sel_e        fw_a_sel, fw_b_sel;
  logic [rv_isa_pkg::XLEN-1:0] rdata_a, rdata_b;
  logic [rv_isa_pkg::XLEN-1:0] operand_a, operand_b;
  logic [rv_isa_pkg::XLEN-1:0] store_data, branch_target;
  logic [1:0]                  rs_used;
  logic                        load_stall;
  logic                        accept;
  logic                        retire;

  ////////////////////
  // Decode and operands
  id_decoder u_decoder (
    .instr_i ( if_id_i.instr ),
    .ctrl_o  ( ctrl          )
  );

  id_regfile u_regfile (
    .clk       ( clk                        ),
    .rst_n     ( rst_n                      ),
    .raddr_a_i ( if_id_i.instr.r_fmt.rs1    ),
    .raddr_b_i ( if_id_i.instr.r_fmt.rs2    ),
    .rdata_a_o ( rdata_a                    ),
    .rdata_b_o ( rdata_b                    ),
    .wr_i      ( wb_wr_i                    )
  );

  id_operand_sel u_operand_sel (
    .instr_i         ( if_id_i.instr ),
    .pc_i            ( if_id_i.pc    ),
    .ctrl_i          ( ctrl          ),
    .rdata_a_i       ( rdata_a       ),
    .rdata_b_i       ( rdata_b       ),
    .ex_fwd_i        ( ex_fwd_i      ),
    .wb_wr_i         ( wb_wr_i       ),
    .fw_a_sel_i      ( fw_a_sel      ),
    .fw_b_sel_i      ( fw_b_sel      ),
    .operand_a_o     ( operand_a     ),
    .operand_b_o     ( operand_b     ),
    .store_data_o    ( store_data    ),
    .branch_target_o ( branch_target )
  );

  // No stall from an empty slot
  assign rs_used = if_id_i.valid ? ctrl.rs_used : 2'b00;

  id_hazard_unit u_hazard_unit (
    .instr_i      ( if_id_i.instr ),
    .rs_used_i    ( rs_used       ),
    .ex_fwd_i     ( ex_fwd_i      ),
    .wb_wr_i      ( wb_wr_i       ),
    .id_ex_i      ( id_ex_o       ),
    .fw_a_sel_o   ( fw_a_sel      ),
    .fw_b_sel_o   ( fw_b_sel      ),
    .load_stall_o ( load_stall    )
  );

  ////////////////////
  // Flow control
  assign id_ready_o = ex_ready_i && !load_stall;
  assign accept     = if_id_i.valid && id_ready_o;

  // Load on accept, bubble if EX drains, hold otherwise
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      id_ex_o <= '0;
    end else if (accept) begin
      id_ex_o.valid         <= 1'b1;
      id_ex_o.pc            <= if_id_i.pc;
      id_ex_o.alu_op        <= ctrl.alu_op;
      id_ex_o.operand_a     <= operand_a;
      id_ex_o.operand_b     <= operand_b;
      id_ex_o.store_data    <= store_data;
      id_ex_o.branch_target <= branch_target;
      id_ex_o.rd            <= if_id_i.instr.r_fmt.rd;
      id_ex_o.rf_we         <= ctrl.rf_we;
      id_ex_o.data_req      <= ctrl.data_req;
      id_ex_o.data_we       <= ctrl.data_we;
      id_ex_o.is_branch     <= ctrl.is_branch;
    end else if (ex_ready_i) begin
      // Payload left as is, bubble has no side effects
      id_ex_o.valid     <= 1'b0;
      id_ex_o.rf_we     <= 1'b0;
      id_ex_o.data_req  <= 1'b0;
      id_ex_o.data_we   <= 1'b0;
      id_ex_o.is_branch <= 1'b0;
    end
  end

  ////////////////////
  // Performance events
  assign retire = accept && !ctrl.illegal;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      evt_instret_o <= 1'b0;
      evt_load_o    <= 1'b0;
      evt_store_o   <= 1'b0;
      evt_jump_o    <= 1'b0;
      evt_branch_o  <= 1'b0;
    end else begin
      evt_instret_o <= retire;
      evt_load_o    <= retire && ctrl.data_req && !ctrl.data_we;
      evt_store_o   <= retire && ctrl.data_req && ctrl.data_we;
      evt_jump_o    <= retire && ctrl.is_jump;
      evt_branch_o  <= retire && ctrl.is_branch;
    end
  end

endmodule

// ==== rtl/id_hazard_unit.sv ====
// Forwarding and load-use hazard detection
`timescale 1ns/1ps

module id_hazard_unit (
  input  rv_isa_pkg::instr_fmt_u instr_i,
  input  logic [1:0]             rs_used_i,
  input  id_pipe_pkg::rf_wr_t    ex_fwd_i,
  input  id_pipe_pkg::rf_wr_t    wb_wr_i,
  input  id_pipe_pkg::id_ex_t    id_ex_i,
  output id_pipe_pkg::fw_sel_e   fw_a_sel_o,
  output id_pipe_pkg::fw_sel_e   fw_b_sel_o,
  output logic                   load_stall_o
);

  logic ex_is_load;
  logic rs1_hit;
  logic rs2_hit;

  // EX wins over WB, x0 is never forwarded
  function automatic id_pipe_pkg::fw_sel_e fw_select(
    input rv_isa_pkg::rf_addr_t rs,
    input id_pipe_pkg::rf_wr_t  ex,
    input id_pipe_pkg::rf_wr_t  wb
  );
    id_pipe_pkg::fw_sel_e sel;
    if (ex.we && ex.waddr != '0 && ex.waddr == rs) begin
      sel = id_pipe_pkg::FW_EX;
    end else if (wb.we && wb.waddr != '0 && wb.waddr == rs) begin
      sel = id_pipe_pkg::FW_WB;
    end else begin
      sel = id_pipe_pkg::FW_RF;
    end
    return sel;
  endfunction

  assign fw_a_sel_o = fw_select(instr_i.r_fmt.rs1, ex_fwd_i, wb_wr_i);
  assign fw_b_sel_o = fw_select(instr_i.r_fmt.rs2, ex_fwd_i, wb_wr_i);

  // Load data not there before WB
  assign ex_is_load = id_ex_i.valid && id_ex_i.data_req && !id_ex_i.data_we &&
                      id_ex_i.rd != '0;
  assign rs1_hit = rs_used_i[0] && id_ex_i.rd == instr_i.r_fmt.rs1;
  assign rs2_hit = rs_used_i[1] && id_ex_i.rd == instr_i.r_fmt.rs2;

  assign load_stall_o = ex_is_load && (rs1_hit || rs2_hit);

endmodule

// ==== rtl/id_operand_sel.sv ====
// Immediate and operand selection
`timescale 1ns/1ps

module id_operand_sel (
  input  rv_isa_pkg::instr_fmt_u      instr_i,
  input  logic [rv_isa_pkg::XLEN-1:0] pc_i,
  input  id_pipe_pkg::dec_ctrl_t      ctrl_i,
  input  logic [rv_isa_pkg::XLEN-1:0] rdata_a_i,
  input  logic [rv_isa_pkg::XLEN-1:0] rdata_b_i,
  input  id_pipe_pkg::rf_wr_t         ex_fwd_i,
  input  id_pipe_pkg::rf_wr_t         wb_wr_i,
  input  id_pipe_pkg::fw_sel_e        fw_a_sel_i,
  input  id_pipe_pkg::fw_sel_e        fw_b_sel_i,
  output logic [rv_isa_pkg::XLEN-1:0] operand_a_o,
  output logic [rv_isa_pkg::XLEN-1:0] operand_b_o,
  output logic [rv_isa_pkg::XLEN-1:0] store_data_o,
  output logic [rv_isa_pkg::XLEN-1:0] branch_target_o
);

  rv_isa_pkg::r_fmt_t          r;
  rv_isa_pkg::u_fmt_t          u;
  logic [rv_isa_pkg::XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [rv_isa_pkg::XLEN-1:0] imm;
  logic [rv_isa_pkg::XLEN-1:0] rs1_fw, rs2_fw;
  logic [rv_isa_pkg::XLEN-1:0] jalr_sum;
  logic                        is_jalr;

  // Register file or a pending write
  function automatic logic [rv_isa_pkg::XLEN-1:0] fw_mux(
    input id_pipe_pkg::fw_sel_e        sel,
    input logic [rv_isa_pkg::XLEN-1:0] rf_val,
    input logic [rv_isa_pkg::XLEN-1:0] ex_val,
    input logic [rv_isa_pkg::XLEN-1:0] wb_val
  );
    logic [rv_isa_pkg::XLEN-1:0] val;
    case (sel)
      id_pipe_pkg::FW_EX: val = ex_val;
      id_pipe_pkg::FW_WB: val = wb_val;
      default:            val = rf_val;
    endcase
    return val;
  endfunction

  ////////////////////
  // Immediates
  assign r = instr_i.r_fmt;
  assign u = instr_i.u_fmt;

  assign imm_i = {{20{r.funct7[6]}}, r.funct7, r.rs2};
  assign imm_s = {{20{r.funct7[6]}}, r.funct7, r.rd};
  assign imm_b = {{19{r.funct7[6]}}, r.funct7[6], r.rd[0], r.funct7[5:0], r.rd[4:1], 1'b0};
  assign imm_u = {u.imm, 12'b0};
  // J bits sit in the upper immediate as 20|10:1|11|19:12
  assign imm_j = {{12{u.imm[19]}}, u.imm[7:0], u.imm[8], u.imm[18:9], 1'b0};

  always_comb begin
    case (ctrl_i.imm_sel)
      id_pipe_pkg::IMM_S: imm = imm_s;
      id_pipe_pkg::IMM_B: imm = imm_b;
      id_pipe_pkg::IMM_U: imm = imm_u;
      id_pipe_pkg::IMM_J: imm = imm_j;
      default:            imm = imm_i;
    endcase
  end

  ////////////////////
  // Forwarding
  assign rs1_fw = fw_mux(fw_a_sel_i, rdata_a_i, ex_fwd_i.wdata, wb_wr_i.wdata);
  assign rs2_fw = fw_mux(fw_b_sel_i, rdata_b_i, ex_fwd_i.wdata, wb_wr_i.wdata);

  ////////////////////
  // ALU operands
  always_comb begin
    case (ctrl_i.op_a_sel)
      id_pipe_pkg::OPA_PC:   operand_a_o = pc_i;
      id_pipe_pkg::OPA_ZERO: operand_a_o = '0;
      default:               operand_a_o = rs1_fw;
    endcase
    case (ctrl_i.op_b_sel)
      id_pipe_pkg::OPB_IMM: operand_b_o = imm;
      id_pipe_pkg::OPB_PC4: operand_b_o = id_pipe_pkg::PC_INCR;
      default:              operand_b_o = rs2_fw;
    endcase
  end

  assign store_data_o = rs2_fw;

  // Jumps using the I immediate are JALR
  assign is_jalr  = ctrl_i.is_jump && ctrl_i.imm_sel == id_pipe_pkg::IMM_I;
  assign jalr_sum = rs1_fw + imm;
  // PC relative for branches and JAL, bit 0 dropped for JALR
  assign branch_target_o = is_jalr ? {jalr_sum[rv_isa_pkg::XLEN-1:1], 1'b0} : pc_i + imm;

endmodule

// ==== rtl/id_regfile.sv ====
// Integer register file
`timescale 1ns/1ps

module id_regfile (
  input  logic                        clk,
  input  logic                        rst_n,
  input  rv_isa_pkg::rf_addr_t        raddr_a_i,
  input  rv_isa_pkg::rf_addr_t        raddr_b_i,
  output logic [rv_isa_pkg::XLEN-1:0] rdata_a_o,
  output logic [rv_isa_pkg::XLEN-1:0] rdata_b_o,
  input  id_pipe_pkg::rf_wr_t         wr_i
);

  // Storage for x1 to x31, x0 has none
  logic [rv_isa_pkg::XLEN-1:0] regs_q [rv_isa_pkg::NUM_REGS-1:1];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < rv_isa_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.we && wr_i.waddr != '0) begin
      regs_q[wr_i.waddr] <= wr_i.wdata;
    end
  end

  // Combinational reads, x0 hard-wired
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// ==== rtl/id_decoder.sv ====
// RV32I instruction decoder
`timescale 1ns/1ps

module id_decoder (
  input  rv_isa_pkg::instr_fmt_u instr_i,
  output id_pipe_pkg::dec_ctrl_t ctrl_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal;

  // Register and immediate arithmetic, alt picks SUB or SRA
  function automatic id_pipe_pkg::alu_op_e arith_op(
    input logic [2:0] f3,
    input logic       alt
  );
    id_pipe_pkg::alu_op_e op;
    case (f3)
      3'b000:  op = alt ? id_pipe_pkg::ALU_SUB : id_pipe_pkg::ALU_ADD;
      3'b001:  op = id_pipe_pkg::ALU_SLL;
      3'b010:  op = id_pipe_pkg::ALU_SLT;
      3'b011:  op = id_pipe_pkg::ALU_SLTU;
      3'b100:  op = id_pipe_pkg::ALU_XOR;
      3'b101:  op = alt ? id_pipe_pkg::ALU_SRA : id_pipe_pkg::ALU_SRL;
      3'b110:  op = id_pipe_pkg::ALU_OR;
      default: op = id_pipe_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  // Branch compare, 010 and 011 caught as illegal by the caller
  function automatic id_pipe_pkg::alu_op_e branch_op(input logic [2:0] f3);
    id_pipe_pkg::alu_op_e op;
    case (f3)
      3'b001:  op = id_pipe_pkg::ALU_NE;
      3'b100:  op = id_pipe_pkg::ALU_LT;
      3'b101:  op = id_pipe_pkg::ALU_GE;
      3'b110:  op = id_pipe_pkg::ALU_LTU;
      3'b111:  op = id_pipe_pkg::ALU_GEU;
      default: op = id_pipe_pkg::ALU_EQ;
    endcase
    return op;
  endfunction

  assign opcode = instr_i.r_fmt.opcode;
  assign funct3 = instr_i.r_fmt.funct3;
  assign funct7 = instr_i.r_fmt.funct7;

  always_comb begin
    // Defaults describe a plain register-register ADD
    ctrl_o          = '0;
    ctrl_o.alu_op   = id_pipe_pkg::ALU_ADD;
    ctrl_o.op_a_sel = id_pipe_pkg::OPA_REG;
    ctrl_o.op_b_sel = id_pipe_pkg::OPB_REG;
    ctrl_o.imm_sel  = id_pipe_pkg::IMM_I;
    illegal         = 1'b0;

    case (opcode)
      rv_isa_pkg::OPC_OP: begin
        ctrl_o.alu_op  = arith_op(funct3, funct7[5]);
        ctrl_o.rf_we   = 1'b1;
        ctrl_o.rs_used = 2'b11;
        // Alternate encoding only for SUB and SRA
        illegal = !(funct7 == 7'h00 ||
                    (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        ctrl_o.alu_op   = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
        ctrl_o.op_b_sel = id_pipe_pkg::OPB_IMM;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.rs_used  = 2'b01;
        // Shifts keep funct7 in the upper immediate bits
        illegal = (funct3 == 3'b001 && funct7 != 7'h00) ||
                  (funct3 == 3'b101 && funct7 != 7'h00 && funct7 != 7'h20);
      end
      rv_isa_pkg::OPC_LUI: begin
        ctrl_o.op_a_sel = id_pipe_pkg::OPA_ZERO;
        ctrl_o.op_b_sel = id_pipe_pkg::OPB_IMM;
        ctrl_o.imm_sel  = id_pipe_pkg::IMM_U;
        ctrl_o.rf_we    = 1'b1;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        ctrl_o.op_a_sel = id_pipe_pkg::OPA_PC;
        ctrl_o.op_b_sel = id_pipe_pkg::OPB_IMM;
        ctrl_o.imm_sel  = id_pipe_pkg::IMM_U;
        ctrl_o.rf_we    = 1'b1;
      end
      rv_isa_pkg::OPC_LOAD: begin
        ctrl_o.op_b_sel = id_pipe_pkg::OPB_IMM;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.data_req = 1'b1;
        ctrl_o.rs_used  = 2'b01;
        // LB LH LW LBU LHU only
        illegal = funct3 == 3'b011 || funct3[2:1] == 2'b11;
      end
      rv_isa_pkg::OPC_STORE: begin
        ctrl_o.op_b_sel = id_pipe_pkg::OPB_IMM;
        ctrl_o.imm_sel  = id_pipe_pkg::IMM_S;
        ctrl_o.data_req = 1'b1;
        ctrl_o.data_we  = 1'b1;
        ctrl_o.rs_used  = 2'b11;
        illegal = funct3[2] || funct3[1:0] == 2'b11;
      end
      rv_isa_pkg::OPC_BRANCH: begin
        ctrl_o.alu_op    = branch_op(funct3);
        ctrl_o.imm_sel   = id_pipe_pkg::IMM_B;
        ctrl_o.is_branch = 1'b1;
        ctrl_o.rs_used   = 2'b11;
        illegal = funct3[2:1] == 2'b01;
      end
      rv_isa_pkg::OPC_JAL: begin
        // Link value PC + 4 goes through the ALU
        ctrl_o.op_a_sel = id_pipe_pkg::OPA_PC;
        ctrl_o.op_b_sel = id_pipe_pkg::OPB_PC4;
        ctrl_o.imm_sel  = id_pipe_pkg::IMM_J;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.is_jump  = 1'b1;
      end
      rv_isa_pkg::OPC_JALR: begin
        ctrl_o.op_a_sel = id_pipe_pkg::OPA_PC;
        ctrl_o.op_b_sel = id_pipe_pkg::OPB_PC4;
        ctrl_o.rf_we    = 1'b1;
        ctrl_o.is_jump  = 1'b1;
        ctrl_o.rs_used  = 2'b01;
        illegal = funct3 != 3'b000;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase

    // Illegal words must not touch state or cause a stall
    if (illegal) begin
      ctrl_o.rf_we     = 1'b0;
      ctrl_o.data_req  = 1'b0;
      ctrl_o.data_we   = 1'b0;
      ctrl_o.is_branch = 1'b0;
      ctrl_o.is_jump   = 1'b0;
      ctrl_o.rs_used   = 2'b00;
    end
    ctrl_o.illegal = illegal;
  end

endmodule

// ==== rtl/id_pipe_pkg.sv ====
// Decode stage pipeline types
package id_pipe_pkg;

  // Link address offset, no compressed instructions
  localparam logic [rv_isa_pkg::XLEN-1:0] PC_INCR = 32'd4;

  // Arithmetic ops first, branch compares in the upper half
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT,
    ALU_SLTU, ALU_XOR, ALU_SRL, ALU_SRA,
    ALU_OR, ALU_AND,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO} op_a_sel_e;
  typedef enum logic [1:0] {OPB_REG, OPB_IMM, OPB_PC4} op_b_sel_e;
  typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_e;
  typedef enum logic [1:0] {FW_RF, FW_EX, FW_WB} fw_sel_e;

  // Fetch to decode
  typedef struct packed {
    logic                         valid;
    logic [rv_isa_pkg::XLEN-1:0]  pc;
    rv_isa_pkg::instr_fmt_u       instr;
  } if_id_t;

  // Register write port, EX forward and WB write
  typedef struct packed {
    logic                         we;
    rv_isa_pkg::rf_addr_t         waddr;
    logic [rv_isa_pkg::XLEN-1:0]  wdata;
  } rf_wr_t;

  // Decoder output
  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_sel_e   imm_sel;
    logic       rf_we;
    logic       data_req;
    logic       data_we;
    logic       is_branch;
    logic       is_jump;
    logic       illegal;
    logic [1:0] rs_used;    // bit 0 rs1, bit 1 rs2
  } dec_ctrl_t;

  // Decode to execute
  typedef struct packed {
    logic                         valid;
    logic [rv_isa_pkg::XLEN-1:0]  pc;
    alu_op_e                      alu_op;
    logic [rv_isa_pkg::XLEN-1:0]  operand_a;
    logic [rv_isa_pkg::XLEN-1:0]  operand_b;
    logic [rv_isa_pkg::XLEN-1:0]  store_data;
    logic [rv_isa_pkg::XLEN-1:0]  branch_target;
    rv_isa_pkg::rf_addr_t         rd;
    logic                         rf_we;
    logic                         data_req;
    logic                         data_we;
    logic                         is_branch;
  } id_ex_t;

endpackage

// ==== rtl/rv_isa_pkg.sv ====
// RV32I instruction set definitions
package rv_isa_pkg;

  // Data path and register file geometry
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  typedef logic [REG_ADDR_W-1:0] rf_addr_t;

  // Major opcodes of the kept base integer subset
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_AUIPC  = 7'b0010111,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111,
    OPC_BRANCH = 7'b1100011,
    OPC_JALR   = 7'b1100111,
    OPC_JAL    = 7'b1101111
  } opcode_e;

  // Register layout, also the source of I, S and B immediates
  typedef struct packed {
    logic [6:0] funct7;
    rf_addr_t   rs2;
    rf_addr_t   rs1;
    logic [2:0] funct3;
    rf_addr_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  // Upper immediate layout, J immediate is scrambled inside imm
  typedef struct packed {
    logic [19:0] imm;
    rf_addr_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    u_fmt_t u_fmt;
  } instr_fmt_u;

endpackage
